// ==== source/tlp_pkg.sv ====
/* TLP layer types and field codes */
package tlp_pkg;

	// Widest BAR vector and slave window the structs can carry
	localparam int BAR_W_MAX     = 8;
	localparam int SLV_ADR_W_MAX = 24;

	// ------------------------------------------------------------
	// Header field codes
	// ------------------------------------------------------------
	localparam logic [1:0] FMT_3DW_DATA = 2'b10;
	localparam logic [1:0] FMT_4DW      = 2'b01;
	localparam logic [4:0] TYPE_CPLD    = 5'b01010;
	localparam logic [2:0] CPL_SC       = 3'b000;

	// Request class decoded from fmt/type
	typedef enum logic [2:0] {
		KIND_MEM,
		KIND_MEM_LK,
		KIND_IO,
		KIND_CFG0,
		KIND_CFG1,
		KIND_MSG,
		KIND_CPL,
		KIND_CPL_LK
	} tlp_kind_e;

	// ------------------------------------------------------------
	// Headers
	// ------------------------------------------------------------
	typedef struct packed {
		logic [1:0]           fmt;
		logic [4:0]           typ;
		logic [2:0]           tc;
		logic                 td;
		logic                 ep;
		logic [1:0]           attr;
		logic [9:0]           length;
		logic [15:0]          req_id;
		logic [7:0]           tag;
		logic [3:0]           first_be;
		logic [3:0]           last_be;
		logic [47:2]          addr;
		tlp_kind_e            kind;
		logic [BAR_W_MAX-1:0] bar_hit;
	} tlp_hdr_t;

	typedef struct packed {
		logic [7:0] bus;
		logic [4:0] dev;
		logic [2:0] func;
	} cpl_id_t;

	typedef struct packed {
		logic [9:0]  length;
		logic [15:0] req_id;
		logic [7:0]  tag;
		logic [11:0] byte_cnt;
		logic [6:0]  lower_addr;
	} cpl_hdr_t;

	// ------------------------------------------------------------
	// Streams and side buses
	// ------------------------------------------------------------
	typedef struct packed {
		logic [15:0] data;
		logic        last;
	} rx_word_t;

	typedef struct packed {
		logic [BAR_W_MAX-1:0]     bar;
		logic                     ce;
		logic                     we;
		logic [SLV_ADR_W_MAX-1:0] adr;
		logic [15:0]              dat;
		logic [1:0]               sel;
	} slv_req_t;

	// Receive credit return, one cycle pulses
	typedef struct packed {
		logic       ph;
		logic       pd;
		logic       nph;
		logic       npd;
		logic [7:0] pd_num;
	} rx_credit_t;

endpackage

// ==== source/tlp_rx_parser.sv ====
/* TLP receive parser */
module tlp_rx_parser #(
	parameter int N_BAR = 7
) (
	input  logic                pcie_clk,
	input  logic                sys_rst,
	input  logic                rx_st_i,
	input  logic                rx_end_i,
	input  logic [15:0]         rx_data_i,
	input  logic [N_BAR-1:0]    rx_bar_hit_i,
	output tlp_pkg::tlp_hdr_t   hdr_o,
	output logic                hdr_valid_o,
	output tlp_pkg::rx_word_t   wdata_o,
	output tlp_pkg::rx_credit_t credits_o
);
	import tlp_pkg::*;

	typedef enum logic [3:0] {
		RX_IDLE,
		RX_HDR1,
		RX_REQID,
		RX_TAG,
		RX_ADR63,
		RX_ADR47,
		RX_ADR31,
		RX_ADR15,
		RX_BODY
	} rx_state_e;

	rx_state_e  state;
	tlp_kind_e  kind_w;
	logic       has_data;
	logic       is_4dw;
	logic       bar_any;
	logic [7:0] pd_dw4;

	always_comb begin
		if (rx_data_i[12]) begin
			kind_w = KIND_MSG;
		end else if (rx_data_i[11]) begin
			kind_w = rx_data_i[8] ? KIND_CPL_LK : KIND_CPL;
		end else begin
			case (rx_data_i[10:8])
				3'b000:  kind_w = KIND_MEM;
				3'b001:  kind_w = KIND_MEM_LK;
				3'b010:  kind_w = KIND_IO;
				3'b100:  kind_w = KIND_CFG0;
				default: kind_w = KIND_CFG1;
			endcase
		end
	end

	assign has_data = (hdr_o.fmt & FMT_3DW_DATA) != 2'b00;
	assign is_4dw   = (hdr_o.fmt & FMT_4DW) != 2'b00;
	assign bar_any  = hdr_o.bar_hit != '0;
	// Data credits count 4 DW units, rounded up
	assign pd_dw4   = hdr_o.length[9:2] + {7'd0, hdr_o.length[1:0] != 2'b00};

	// ------------------------------------------------------------
	// Header field capture
	// ------------------------------------------------------------
	always_ff @(posedge pcie_clk) begin
		case (state)
			RX_IDLE: begin
				if (rx_st_i) begin
					hdr_o.fmt     <= rx_data_i[14:13];
					hdr_o.typ     <= rx_data_i[12:8];
					hdr_o.tc      <= rx_data_i[6:4];
					hdr_o.kind    <= kind_w;
					hdr_o.bar_hit <= BAR_W_MAX'(rx_bar_hit_i);
				end
			end
			RX_HDR1: begin
				hdr_o.td     <= rx_data_i[15];
				hdr_o.ep     <= rx_data_i[14];
				hdr_o.attr   <= rx_data_i[13:12];
				hdr_o.length <= rx_data_i[9:0];
			end
			RX_REQID: begin
				hdr_o.req_id <= rx_data_i;
			end
			RX_TAG: begin
				hdr_o.tag      <= rx_data_i[15:8];
				hdr_o.last_be  <= rx_data_i[7:4];
				hdr_o.first_be <= rx_data_i[3:0];
				if (!is_4dw) begin
					hdr_o.addr[47:32] <= '0;
				end
			end
			RX_ADR47: hdr_o.addr[47:32] <= rx_data_i;
			RX_ADR31: hdr_o.addr[31:16] <= rx_data_i;
			RX_ADR15: hdr_o.addr[15:2]  <= rx_data_i[15:2];
			default: begin
			end
		endcase
	end

	// ------------------------------------------------------------
	// Word sequencing and credit return
	// ------------------------------------------------------------
	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state       <= RX_IDLE;
			hdr_valid_o <= 1'b0;
			credits_o   <= '0;
		end else begin
			hdr_valid_o <= 1'b0;
			credits_o   <= '0;
			case (state)
				RX_IDLE: begin
					if (rx_st_i) begin
						state <= RX_HDR1;
					end
				end
				RX_HDR1: begin
					// Completions are only counted, their header is not parsed
					if (hdr_o.kind == KIND_CPL || hdr_o.kind == KIND_CPL_LK) begin
						state <= RX_BODY;
					end else begin
						state <= RX_REQID;
					end
				end
				RX_REQID: state <= RX_TAG;
				RX_TAG:   state <= is_4dw ? RX_ADR63 : RX_ADR31;
				RX_ADR63: state <= RX_ADR47;
				RX_ADR47: state <= RX_ADR31;
				RX_ADR31: state <= RX_ADR15;
				RX_ADR15: begin
					hdr_valid_o <= hdr_o.kind == KIND_MEM && bar_any;
					state       <= RX_BODY;
				end
				default: begin
				end
			endcase
			if (rx_end_i && state != RX_IDLE) begin
				state <= RX_IDLE;
				case (hdr_o.kind)
					KIND_MEM, KIND_MEM_LK: begin
						if (bar_any && has_data) begin
							credits_o.ph     <= 1'b1;
							credits_o.pd     <= 1'b1;
							credits_o.pd_num <= pd_dw4;
						end else if (bar_any) begin
							credits_o.nph <= 1'b1;
						end
					end
					KIND_IO, KIND_CFG0, KIND_CFG1: begin
						credits_o.nph <= 1'b1;
						credits_o.npd <= has_data;
					end
					KIND_MSG: begin
						credits_o.ph     <= 1'b1;
						credits_o.pd     <= has_data;
						credits_o.pd_num <= has_data ? pd_dw4 : 8'd0;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Payload stream one cycle behind the link
	always_ff @(posedge pcie_clk) begin
		wdata_o.data <= rx_data_i;
		wdata_o.last <= rx_end_i;
	end

endmodule

// ==== source/tlp_completer.sv ====
/* BAR slave sequencer */
module tlp_completer #(
	parameter int N_BAR     = 7,
	parameter int SLV_ADR_W = 19
) (
	input  logic              pcie_clk,
	input  logic              sys_rst,
	input  tlp_pkg::tlp_hdr_t hdr_i,
	input  logic              hdr_valid_i,
	input  tlp_pkg::rx_word_t wdata_i,
	output tlp_pkg::slv_req_t slv_o,
	input  logic [15:0]       slv_dat_i,
	output tlp_pkg::cpl_hdr_t cpl_o,
	output logic              cpl_valid_o,
	input  logic              data_rdy_i,
	output logic [15:0]       cpl_data_o,
	output logic              cpl_done_o
);
	import tlp_pkg::*;

	typedef enum logic [2:0] {
		SLV_IDLE,
		SLV_WRITE,
		SLV_RD_HDR,
		SLV_RD_DATA,
		SLV_RD_TAIL
	} slv_state_e;

	slv_state_e           state;
	tlp_hdr_t             req;
	logic [SLV_ADR_W-1:0] adr_q;
	logic [10:0]          hw_idx;
	logic                 first_dw;
	logic                 last_dw;
	logic                 last_hw;
	logic [3:0]           lane_be;
	logic [1:0]           wr_sel;
	logic [11:0]          byte_cnt;
	logic [6:0]           low_adr;
	logic                 iss_last;
	logic                 rd_vld;
	logic                 rd_last;

	// Offset of the lowest enabled byte
	function automatic logic [1:0] be_low(input logic [3:0] be);
		casez (be)
			4'b???1: be_low = 2'd0;
			4'b??10: be_low = 2'd1;
			4'b?100: be_low = 2'd2;
			4'b1000: be_low = 2'd3;
			default: be_low = 2'd0;
		endcase
	endfunction

	// Offset of the highest enabled byte
	function automatic logic [1:0] be_high(input logic [3:0] be);
		casez (be)
			4'b1???: be_high = 2'd3;
			4'b01??: be_high = 2'd2;
			4'b001?: be_high = 2'd1;
			default: be_high = 2'd0;
		endcase
	endfunction

	assign first_dw = hw_idx[10:1] == 10'd0;
	assign last_dw  = hw_idx[10:1] == req.length - 10'd1;
	assign last_hw  = last_dw && hw_idx[0];

	// High lane bit is the lower numbered byte of the halfword
	always_comb begin
		if (first_dw) begin
			lane_be = req.first_be;
		end else if (last_dw) begin
			lane_be = req.last_be;
		end else begin
			lane_be = 4'hf;
		end
		wr_sel = hw_idx[0] ? {lane_be[2], lane_be[3]} : {lane_be[0], lane_be[1]};
	end

	always_comb begin
		if (req.length == 10'd1) begin
			if (req.first_be == 4'h0) begin
				byte_cnt = 12'd1;
			end else begin
				byte_cnt = 12'(be_high(req.first_be) - be_low(req.first_be)) + 12'd1;
			end
		end else begin
			byte_cnt = {req.length, 2'b00} - 12'(be_low(req.first_be))
				- 12'(2'd3 - be_high(req.last_be));
		end
		low_adr = {req.addr[6:2], be_low(req.first_be)};
	end

	// ------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------
	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state       <= SLV_IDLE;
			slv_o.ce    <= 1'b0;
			slv_o.we    <= 1'b0;
			cpl_valid_o <= 1'b0;
			cpl_done_o  <= 1'b0;
			iss_last    <= 1'b0;
			rd_vld      <= 1'b0;
			rd_last     <= 1'b0;
		end else begin
			slv_o.ce   <= 1'b0;
			slv_o.we   <= 1'b0;
			cpl_done_o <= 1'b0;
			iss_last   <= 1'b0;
			// Read data is valid one cycle after ce
			rd_vld     <= slv_o.ce && !slv_o.we;
			rd_last    <= iss_last;
			if (rd_vld) begin
				cpl_data_o <= slv_dat_i;
				cpl_done_o <= rd_last;
			end
			if (data_rdy_i) begin
				cpl_valid_o <= 1'b0;
			end
			case (state)
				SLV_IDLE: begin
					if (hdr_valid_i) begin
						req       <= hdr_i;
						slv_o.bar <= BAR_W_MAX'(hdr_i.bar_hit[N_BAR-1:0]);
						adr_q     <= {hdr_i.addr[SLV_ADR_W:2], 1'b0};
						hw_idx    <= '0;
						if ((hdr_i.fmt & FMT_3DW_DATA) != 2'b00) begin
							state <= SLV_WRITE;
						end else begin
							state <= SLV_RD_HDR;
						end
					end
				end
				SLV_WRITE: begin
					slv_o.ce  <= 1'b1;
					slv_o.we  <= 1'b1;
					slv_o.adr <= SLV_ADR_W_MAX'(adr_q);
					slv_o.dat <= wdata_i.data;
					slv_o.sel <= wr_sel;
					adr_q     <= adr_q + 1'b1;
					hw_idx    <= hw_idx + 11'd1;
					if (last_hw || wdata_i.last) begin
						state <= SLV_IDLE;
					end
				end
				SLV_RD_HDR: begin
					cpl_o.length     <= req.length;
					cpl_o.req_id     <= req.req_id;
					cpl_o.tag        <= req.tag;
					cpl_o.byte_cnt   <= byte_cnt;
					cpl_o.lower_addr <= low_adr;
					cpl_valid_o      <= 1'b1;
					state            <= SLV_RD_DATA;
				end
				SLV_RD_DATA: begin
					if (data_rdy_i) begin
						slv_o.ce  <= 1'b1;
						slv_o.adr <= SLV_ADR_W_MAX'(adr_q);
						adr_q     <= adr_q + 1'b1;
						hw_idx    <= hw_idx + 11'd1;
						iss_last  <= last_hw;
						if (last_hw) begin
							state <= SLV_RD_TAIL;
						end
					end
				end
				SLV_RD_TAIL: begin
					// Wait for the last halfword to leave the read pipeline
					if (rd_vld && rd_last) begin
						state <= SLV_IDLE;
					end
				end
				default: state <= SLV_IDLE;
			endcase
		end
	end

endmodule

// ==== source/tlp_tx_framer.sv ====
/* Completion framer */
module tlp_tx_framer (
	input  logic              pcie_clk,
	input  logic              sys_rst,
	input  tlp_pkg::cpl_id_t  cpl_id_i,
	input  tlp_pkg::cpl_hdr_t cpl_i,
	input  logic              cpl_valid_i,
	output logic              data_rdy_o,
	input  logic [15:0]       cpl_data_i,
	input  logic              cpl_done_i,
	output logic              tx_req_o,
	input  logic              tx_rdy_i,
	output logic              tx_st_o,
	output logic              tx_end_o,
	output logic [15:0]       tx_data_o
);
	import tlp_pkg::*;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_WAIT,
		TX_HDR,
		TX_DATA
	} tx_state_e;

	tx_state_e   state;
	logic [2:0]  hcnt;
	logic [15:0] hdr_word;

	// Completion header, one halfword per count
	always_comb begin
		case (hcnt)
			3'd0:    hdr_word = {1'b0, FMT_3DW_DATA, TYPE_CPLD, 1'b0, 3'b000, 4'b0000};
			3'd1:    hdr_word = {6'b000000, cpl_i.length};
			3'd2:    hdr_word = cpl_id_i;
			3'd3:    hdr_word = {CPL_SC, 1'b0, cpl_i.byte_cnt};
			3'd4:    hdr_word = cpl_i.req_id;
			default: hdr_word = {cpl_i.tag, 1'b0, cpl_i.lower_addr};
		endcase
	end

	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state      <= TX_IDLE;
			hcnt       <= 3'd0;
			tx_req_o   <= 1'b0;
			tx_st_o    <= 1'b0;
			tx_end_o   <= 1'b0;
			data_rdy_o <= 1'b0;
		end else begin
			tx_st_o  <= 1'b0;
			tx_end_o <= 1'b0;
			case (state)
				TX_IDLE: begin
					hcnt <= 3'd0;
					if (cpl_valid_i) begin
						tx_req_o <= 1'b1;
						state    <= TX_WAIT;
					end
				end
				TX_WAIT: begin
					if (tx_rdy_i) begin
						tx_req_o  <= 1'b0;
						tx_st_o   <= 1'b1;
						tx_data_o <= hdr_word;
						hcnt      <= 3'd1;
						state     <= TX_HDR;
					end
				end
				TX_HDR: begin
					tx_data_o <= hdr_word;
					hcnt      <= hcnt + 3'd1;
					// Lead time for the slave read pipeline
					if (hcnt == 3'd2) begin
						data_rdy_o <= 1'b1;
					end
					if (hcnt == 3'd5) begin
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					tx_data_o <= cpl_data_i;
					tx_end_o  <= cpl_done_i;
					if (cpl_done_i) begin
						data_rdy_o <= 1'b0;
						state      <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

// ==== source/pcie_tlp_top.sv ====
/* PCIe transaction layer */
module pcie_tlp_top #(
	parameter int N_BAR     = 7,
	parameter int SLV_ADR_W = 19
) (
	input  logic                pcie_clk,
	input  logic                sys_rst,
	input  tlp_pkg::cpl_id_t    cpl_id_i,
	// Receive side
	input  logic                rx_st_i,
	input  logic                rx_end_i,
	input  logic [15:0]         rx_data_i,
	input  logic [N_BAR-1:0]    rx_bar_hit_i,
	output tlp_pkg::rx_credit_t credits_o,
	// Transmit side
	output logic                tx_req_o,
	input  logic                tx_rdy_i,
	output logic                tx_st_o,
	output logic                tx_end_o,
	output logic [15:0]         tx_data_o,
	// Local slave bus
	output tlp_pkg::slv_req_t   slv_o,
	input  logic [15:0]         slv_dat_i
);
	import tlp_pkg::*;

	tlp_hdr_t    hdr;
	logic        hdr_valid;
	rx_word_t    wdata;
	cpl_hdr_t    cpl;
	logic        cpl_valid;
	logic        data_rdy;
	logic [15:0] cpl_data;
	logic        cpl_done;

	tlp_rx_parser #(
		.N_BAR(N_BAR)
	) u_parser (
		.pcie_clk     (pcie_clk),
		.sys_rst      (sys_rst),
		.rx_st_i      (rx_st_i),
		.rx_end_i     (rx_end_i),
		.rx_data_i    (rx_data_i),
		.rx_bar_hit_i (rx_bar_hit_i),
		.hdr_o        (hdr),
		.hdr_valid_o  (hdr_valid),
		.wdata_o      (wdata),
		.credits_o    (credits_o)
	);

	tlp_completer #(
		.N_BAR     (N_BAR),
		.SLV_ADR_W (SLV_ADR_W)
	) u_completer (
		.pcie_clk    (pcie_clk),
		.sys_rst     (sys_rst),
		.hdr_i       (hdr),
		.hdr_valid_i (hdr_valid),
		.wdata_i     (wdata),
		.slv_o       (slv_o),
		.slv_dat_i   (slv_dat_i),
		.cpl_o       (cpl),
		.cpl_valid_o (cpl_valid),
		.data_rdy_i  (data_rdy),
		.cpl_data_o  (cpl_data),
		.cpl_done_o  (cpl_done)
	);

	tlp_tx_framer u_framer (
		.pcie_clk    (pcie_clk),
		.sys_rst     (sys_rst),
		.cpl_id_i    (cpl_id_i),
		.cpl_i       (cpl),
		.cpl_valid_i (cpl_valid),
		.data_rdy_o  (data_rdy),
		.cpl_data_i  (cpl_data),
		.cpl_done_i  (cpl_done),
		.tx_req_o    (tx_req_o),
		.tx_rdy_i    (tx_rdy_i),
		.tx_st_o     (tx_st_o),
		.tx_end_o    (tx_end_o),
		.tx_data_o   (tx_data_o)
	);

endmodule

// ==== test/tb_tlp_table.svh ====
/* TLP stimulus table */
`ifndef TB_TLP_TABLE_SVH
`define TB_TLP_TABLE_SVH

localparam int N_ROWS  = 16;
localparam int MAX_LEN = 5;

// Row kinds
localparam logic [2:0] R_MRD   = 3'd0;
localparam logic [2:0] R_MRD64 = 3'd1;
localparam logic [2:0] R_MWR   = 3'd2;
localparam logic [2:0] R_IORD  = 3'd3;
localparam logic [2:0] R_IOWR  = 3'd4;
localparam logic [2:0] R_CFGRD = 3'd5;
localparam logic [2:0] R_MSG   = 3'd6;
localparam logic [2:0] R_MSGD  = 3'd7;

// kind, length, first/last enable, address, BAR hit, tx_rdy delay, credits
// A delay of 255 draws a random back-pressure length
typedef struct packed {
	logic [2:0]  kind;
	logic [9:0]  len;
	logic [3:0]  fbe;
	logic [3:0]  lbe;
	logic [31:0] addr;
	logic [6:0]  bar;
	logic [7:0]  delay;
	rx_credit_t  cred;
} tlp_row_t;

tlp_row_t rows [N_ROWS];

task automatic fill_table();
	rows[0]  = '{R_MWR,   1, 4'hf, 4'h0, 32'h0000_0100, 7'h01, 0,   '{1, 1, 0, 0, 1}};
	rows[1]  = '{R_MWR,   2, 4'he, 4'h3, 32'h0000_0204, 7'h02, 0,   '{1, 1, 0, 0, 1}};
	rows[2]  = '{R_MWR,   4, 4'h8, 4'h1, 32'h0004_03f0, 7'h01, 0,   '{1, 1, 0, 0, 1}};
	rows[3]  = '{R_MWR,   3, 4'hc, 4'h7, 32'h0000_0500, 7'h04, 0,   '{1, 1, 0, 0, 1}};
	rows[4]  = '{R_MRD,   1, 4'h6, 4'h0, 32'h0000_1008, 7'h01, 0,   '{0, 0, 1, 0, 0}};
	rows[5]  = '{R_MRD,   1, 4'h0, 4'h0, 32'h0000_1044, 7'h01, 3,   '{0, 0, 1, 0, 0}};
	rows[6]  = '{R_MRD,   2, 4'he, 4'h3, 32'h0002_2010, 7'h02, 1,   '{0, 0, 1, 0, 0}};
	rows[7]  = '{R_MRD64, 4, 4'hf, 4'hf, 32'h0001_3020, 7'h40, 255, '{0, 0, 1, 0, 0}};
	rows[8]  = '{R_MRD,   3, 4'h8, 4'h1, 32'h0000_407c, 7'h08, 255, '{0, 0, 1, 0, 0}};
	rows[9]  = '{R_MRD,   2, 4'hf, 4'hf, 32'h0000_5000, 7'h00, 0,   '{0, 0, 0, 0, 0}};
	rows[10] = '{R_MWR,   2, 4'hf, 4'hf, 32'h0000_6000, 7'h00, 0,   '{0, 0, 0, 0, 0}};
	rows[11] = '{R_IORD,  1, 4'hf, 4'h0, 32'h0000_0010, 7'h00, 0,   '{0, 0, 1, 0, 0}};
	rows[12] = '{R_IOWR,  1, 4'h3, 4'h0, 32'h0000_0014, 7'h00, 0,   '{0, 0, 1, 1, 0}};
	rows[13] = '{R_CFGRD, 1, 4'hf, 4'h0, 32'h0000_0008, 7'h00, 0,   '{0, 0, 1, 0, 0}};
	rows[14] = '{R_MSG,   1, 4'h0, 4'h0, 32'h0000_0000, 7'h00, 0,   '{1, 0, 0, 0, 0}};
	rows[15] = '{R_MSGD,  5, 4'h0, 4'h0, 32'h0000_0000, 7'h00, 0,   '{1, 1, 0, 0, 2}};
endtask

// Expand a row into link halfwords; write payload is also kept for checking
task automatic expand_row(input tlp_row_t r, input int idx);
	logic [1:0] fmt;
	logic [4:0] typ;
	words.delete();
	wr_data.delete();
	case (r.kind)
		R_MRD:   {fmt, typ} = {2'b00, 5'b00000};
		R_MRD64: {fmt, typ} = {2'b01, 5'b00000};
		R_MWR:   {fmt, typ} = {2'b10, 5'b00000};
		R_IORD:  {fmt, typ} = {2'b00, 5'b00010};
		R_IOWR:  {fmt, typ} = {2'b10, 5'b00010};
		R_CFGRD: {fmt, typ} = {2'b00, 5'b00100};
		R_MSG:   {fmt, typ} = {2'b01, 5'b10000};
		default: {fmt, typ} = {2'b11, 5'b10000};
	endcase
	words.push_back({1'b0, fmt, typ, 8'h00});
	words.push_back({6'd0, r.len});
	words.push_back(16'h0a00 | 16'(idx));
	words.push_back({8'(idx), r.lbe, r.fbe});
	if (fmt[0]) begin
		words.push_back(16'h0000);
		words.push_back(16'h0000);
	end
	words.push_back(r.addr[31:16]);
	words.push_back({r.addr[15:2], 2'b00});
	if (fmt[1]) begin
		for (int k = 0; k < 2 * r.len; k++) begin
			rnd = lcg_next(rnd);
			words.push_back(rnd[31:16]);
			wr_data.push_back(rnd[31:16]);
		end
	end
endtask

`endif

// ==== test/tb_pcie_tlp.sv ====
/* PCIe transaction layer testbench */
module tb_pcie_tlp;
	timeunit 1ns;
	timeprecision 100ps;
	import tlp_pkg::*;

	localparam int          N_BAR     = 7;
	localparam int          SLV_ADR_W = 19;
	localparam time         T_CLK     = 40ns;
	localparam logic [31:0] SEED      = 32'ha910;

	logic               pcie_clk;
	logic               sys_rst;
	cpl_id_t            cpl_id;
	logic               rx_st;
	logic               rx_end;
	logic [15:0]        rx_data;
	logic [N_BAR-1:0]   rx_bar_hit;
	rx_credit_t         credits;
	logic               tx_req;
	logic               tx_rdy;
	logic               tx_st;
	logic               tx_end;
	logic [15:0]        tx_data;
	slv_req_t           slv;
	logic [15:0]        slv_dat;

	logic [31:0]        rnd;
	logic [15:0]        words[$];
	logic [15:0]        wr_data[$];
	slv_req_t           slv_q[$];
	logic [17:0]        tx_q[$];
	logic [15:0]        bar_mem[logic [31:0]];
	logic [31:0]        rd_key;
	logic               in_pkt;
	int                 errors;
	int                 cycles;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	`include "tb_tlp_table.svh"

	localparam int LIMIT = 200 + N_ROWS * (8 + 4 * MAX_LEN + 16 + 60);

	pcie_tlp_top #(
		.N_BAR     (N_BAR),
		.SLV_ADR_W (SLV_ADR_W)
	) DUT (
		.pcie_clk     (pcie_clk),
		.sys_rst      (sys_rst),
		.cpl_id_i     (cpl_id),
		.rx_st_i      (rx_st),
		.rx_end_i     (rx_end),
		.rx_data_i    (rx_data),
		.rx_bar_hit_i (rx_bar_hit),
		.credits_o    (credits),
		.tx_req_o     (tx_req),
		.tx_rdy_i     (tx_rdy),
		.tx_st_o      (tx_st),
		.tx_end_o     (tx_end),
		.tx_data_o    (tx_data),
		.slv_o        (slv),
		.slv_dat_i    (slv_dat)
	);

	initial begin
		pcie_clk = 1'b0;
		forever #(T_CLK / 2) pcie_clk = ~pcie_clk;
	end

	always @(posedge pcie_clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: no result after %0d clock cycles", LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// Fill pattern over the whole BAR and address, overlaid by recorded writes
	function automatic logic [15:0] mem_read(input logic [31:0] key);
		logic [31:0] v;
		if (bar_mem.exists(key)) begin
			return bar_mem[key];
		end
		v = lcg_next(SEED ^ key);
		return v[31:16];
	endfunction

	// ------------------------------------------------------------
	// BAR model and monitors
	// ------------------------------------------------------------
	always @(negedge pcie_clk) begin
		slv_dat = mem_read(rd_key);
		if (slv.ce) begin
			slv_q.push_back(slv);
			rd_key = {slv.bar, slv.adr};
			if (slv.we) begin
				bar_mem[{slv.bar, slv.adr}] = slv.dat;
			end
		end
		if (tx_st || in_pkt) begin
			tx_q.push_back({tx_end, tx_st, tx_data});
			in_pkt = !tx_end;
		end
	end

	task automatic check_credits(input rx_credit_t got, input rx_credit_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s credits %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_slv(input slv_req_t got, input slv_req_t exp, input bit with_data,
			input string what);
		if (got.bar !== exp.bar || got.ce !== exp.ce || got.we !== exp.we
				|| got.adr !== exp.adr
				|| (with_data && (got.dat !== exp.dat || got.sel !== exp.sel))) begin
			errors++;
			$display("Fail %0t: %s slave cycle %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cpl(input cpl_hdr_t got, input cpl_hdr_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s completion header %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: %s word %h expected %h", $time, what, got, exp);
		end
	endtask

	function automatic int low_byte(input logic [3:0] be);
		int res;
		res = 0;
		for (int i = 3; i >= 0; i--) begin
			if (be[i]) res = i;
		end
		return res;
	endfunction

	function automatic int high_byte(input logic [3:0] be);
		int res;
		res = 0;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) res = i;
		end
		return res;
	endfunction

	task automatic send_tlp(input tlp_row_t r);
		for (int k = 0; k < words.size(); k++) begin
			@(negedge pcie_clk);
			rx_st      = k == 0;
			rx_end     = k == words.size() - 1;
			rx_data    = words[k];
			rx_bar_hit = r.bar;
		end
		@(negedge pcie_clk);
		rx_st  = 1'b0;
		rx_end = 1'b0;
		check_credits(credits, r.cred, "rx_end");
	endtask

	task automatic run_write(input tlp_row_t r);
		slv_req_t    exp;
		logic [3:0]  be;
		logic [19:0] base;
		int          dw;
		while (slv_q.size() < 2 * r.len) @(negedge pcie_clk);
		repeat (3) @(negedge pcie_clk);
		if (slv_q.size() != 2 * r.len) begin
			errors++;
			$display("Fail %0t: %0d slave writes for %0d DW", $time, slv_q.size(), r.len);
		end
		base = r.addr[19:0] >> 1;
		for (int k = 0; k < 2 * r.len && k < slv_q.size(); k++) begin
			dw = k / 2;
			be = dw == 0 ? r.fbe : (dw == r.len - 1 ? r.lbe : 4'hf);
			exp.bar = 8'(r.bar);
			exp.ce  = 1'b1;
			exp.we  = 1'b1;
			exp.adr = 24'(base + k);
			exp.dat = wr_data[k];
			exp.sel = k % 2 ? {be[2], be[3]} : {be[0], be[1]};
			check_slv(slv_q[k], exp, 1'b1, "write");
		end
	endtask

	task automatic run_read(input tlp_row_t r, input int idx);
		int          delay;
		int          n;
		slv_req_t    exp;
		cpl_hdr_t    exp_cpl;
		cpl_hdr_t    got_cpl;
		logic [19:0] base;
		while (!tx_req) @(negedge pcie_clk);
		rnd   = lcg_next(rnd);
		delay = r.delay == 255 ? 1 + rnd[27:16] % 13 : r.delay;
		repeat (delay) begin
			if (!tx_req || tx_st || tx_q.size() != 0) begin
				errors++;
				$display("Link activity while tx_rdy was held low at %0t", $time);
			end
			@(negedge pcie_clk);
		end
		tx_rdy = 1'b1;
		@(negedge pcie_clk);
		tx_rdy = 1'b0;
		check_word({15'd0, tx_req}, 16'd0, "tx_req after tx_rdy");
		while (tx_q.size() == 0 || !tx_q[$][17]) @(negedge pcie_clk);
		n = 6 + 2 * r.len;
		if (tx_q.size() != n || slv_q.size() != 2 * r.len) begin
			errors++;
			$display("Fail %0t: completion has %0d words and %0d slave reads", $time,
				tx_q.size(), slv_q.size());
			return;
		end
		base = r.addr[19:0] >> 1;
		exp_cpl.length     = r.len;
		exp_cpl.req_id     = 16'h0a00 | 16'(idx);
		exp_cpl.tag        = 8'(idx);
		exp_cpl.lower_addr = {r.addr[6:2], 2'(low_byte(r.fbe))};
		if (r.len == 1) begin
			exp_cpl.byte_cnt = r.fbe == 0 ? 12'd1 : 12'(high_byte(r.fbe) - low_byte(r.fbe) + 1);
		end else begin
			exp_cpl.byte_cnt = 12'(4 * r.len - low_byte(r.fbe) - (3 - high_byte(r.lbe)));
		end
		got_cpl = {tx_q[1][9:0], tx_q[4][15:0], tx_q[5][15:8], tx_q[3][11:0], tx_q[5][6:0]};
		check_cpl(got_cpl, exp_cpl, "read");
		check_word(tx_q[0][15:0], 16'h4a00, "fmt/type");
		check_word(tx_q[1][15:0], {6'd0, r.len}, "length");
		check_word(tx_q[2][15:0], cpl_id, "completer ID");
		check_word(tx_q[3][15:0], {4'h0, exp_cpl.byte_cnt}, "status/byte count");
		check_word(tx_q[5][15:0], {exp_cpl.tag, 1'b0, exp_cpl.lower_addr}, "tag/lower address");
		for (int k = 0; k < n; k++) begin
			check_word({14'd0, tx_q[k][17:16]}, {14'd0, k == n - 1, k == 0}, "end/start flags");
		end
		for (int k = 0; k < 2 * r.len; k++) begin
			exp.bar = 8'(r.bar);
			exp.ce  = 1'b1;
			exp.we  = 1'b0;
			exp.adr = 24'(base + k);
			exp.dat = '0;
			exp.sel = '0;
			check_slv(slv_q[k], exp, 1'b0, "read");
			check_word(tx_q[6 + k][15:0], mem_read({exp.bar, exp.adr}), "payload");
		end
	endtask

	task automatic idle_check();
		repeat (10) @(negedge pcie_clk);
		if (slv_q.size() != 0 || tx_q.size() != 0 || tx_req) begin
			errors++;
			$display("Unexpected slave cycle or completion at %0t", $time);
		end
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin
		int err_start;
		sys_rst    = 1'b1;
		cpl_id     = '{8'h03, 5'h02, 3'h1};
		rx_st      = 1'b0;
		rx_end     = 1'b0;
		rx_data    = '0;
		rx_bar_hit = '0;
		tx_rdy     = 1'b0;
		slv_dat    = '0;
		rnd        = SEED;
		rd_key     = '0;
		in_pkt     = 1'b0;
		errors     = 0;
		cycles     = 0;
		fill_table();
		repeat (3) @(posedge pcie_clk);
		@(negedge pcie_clk);
		sys_rst = 1'b0;
		@(negedge pcie_clk);
		check_credits(credits, '0, "reset");
		check_word({11'd0, tx_req, tx_st, tx_end, slv.ce, slv.we}, 16'd0, "reset outputs");
		$display("test reset: %s", errors == 0 ? "ok" : "error");
		for (int i = 0; i < N_ROWS; i++) begin
			err_start = errors;
			expand_row(rows[i], i);
			slv_q.delete();
			tx_q.delete();
			send_tlp(rows[i]);
			if (rows[i].bar != 0 && (rows[i].kind == R_MRD || rows[i].kind == R_MRD64)) begin
				run_read(rows[i], i);
			end else if (rows[i].bar != 0 && rows[i].kind == R_MWR) begin
				run_write(rows[i]);
			end else begin
				idle_check();
			end
			repeat (2) @(negedge pcie_clk);
			$display("test %0d kind %0d len %0d: %s", i, rows[i].kind, rows[i].len,
				errors == err_start ? "ok" : "error");
		end
		$display("Summary: %0d tests, %0d errors", N_ROWS + 1, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+test
source/tlp_pkg.sv
source/tlp_rx_parser.sv
source/tlp_completer.sv
source/tlp_tx_framer.sv
source/pcie_tlp_top.sv
test/tb_pcie_tlp.sv

// ==== Bender.yml ====
package:
  name: pcie_tlp

sources:
  - source/tlp_pkg.sv
  - source/tlp_rx_parser.sv
  - source/tlp_completer.sv
  - source/tlp_tx_framer.sv
  - source/pcie_tlp_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_pcie_tlp.sv
